// ==== flist.f ====
src/conv_pkg.sv
src/csr_pkg.sv
src/line_buffer.sv
src/window_gen.sv
src/conv_mac.sv
src/conv_csr.sv
src/conv_top.sv
testbench/conv_tb_sva.sv
testbench/conv_tb.sv

// ==== testbench/conv_tests.txt ====
# w addr data strb bresp | r addr data rresp | p one image row | e one row of results
# s waits for the results and compares them, all numbers in hex
r 24 00000000 0
w 00 00000001 1 0
w 04 00000001 1 0
w 08 00000001 1 0
w 0c 00000001 1 0
w 10 00000001 1 0
w 14 00000001 1 0
w 18 00000001 1 0
w 1c 00000001 1 0
w 20 00000001 1 0
w 24 00000031 1 0
r 10 00000001 0
r 24 00000031 0
w 30 00000000 f 2
r 30 00000000 2
r 02 00000000 2
# two rows, then a disabled row, then a restart
p ff ff ff ff ff ff ff ff
p 80 80 80 80 80 80 80 80
w 24 00000030 1 0
p 55 55 55 55 55 55 55 55
w 24 00000031 1 0
# frame 1, box kernel, shift 3
p 00 01 02 03 04 05 06 07
p 10 11 12 13 14 15 16 17
p 20 21 22 23 24 25 26 27
p 30 31 32 33 34 35 36 37
p 40 41 42 43 44 45 46 47
p 50 51 52 53 54 55 56 57
e 13 14 15 16 17 18
e 25 26 27 28 29 2a
e 37 38 39 3a 3b 3c
e 49 4a 4b 4c 4d 4e
s
r 28 00000018 0
w 28 00000000 f 0
r 28 00000000 0
# frame 2, horizontal gradient, shift 0, clamps at both ends
w 00 000000ff 1 0
w 04 12345600 f 0
w 08 00000001 1 0
w 0c 000000fe 1 0
w 10 0000007f 0 0
r 10 00000001 0
w 10 00000000 1 0
w 14 00000002 1 0
w 18 000000ff 1 0
w 1c 00000000 1 0
w 20 00000001 1 0
w 24 00000001 1 0
r 04 00000000 0
r 0c 000000fe 0
r 24 00000001 0
p 00 08 20 30 70 90 60 10
p 04 0c 24 34 74 94 64 14
p 08 10 28 38 78 98 68 18
p 0c 14 2c 3c 7c 9c 6c 1c
p 10 18 30 40 80 a0 70 20
p 14 1c 34 44 84 a4 74 24
e 80 a0 ff ff 00 00
e 80 a0 ff ff 00 00
e 80 a0 ff ff 00 00
e 80 a0 ff ff 00 00
s
r 28 00000018 0

// ==== testbench/conv_tb.sv ====
`timescale 1ns/100ps

module conv_tb;

  localparam int IMAGE_WIDTH  = 8;
  localparam int IMAGE_HEIGHT = 6;
  localparam int RESULTS_ROW  = IMAGE_WIDTH - conv_pkg::KERNEL + 1;
  localparam int MAX_GAP      = 3;
  localparam int SEED         = 32'h6873669c;

  logic               clk;
  logic               reset;
  csr_pkg::axil_req_t axil_req;
  csr_pkg::axil_rsp_t axil_rsp;
  logic               pix_valid;
  conv_pkg::pixel_t   pix_data;
  logic               out_valid;
  conv_pkg::pixel_t   out_data;

  string            lines [$];
  logic [31:0]      fields [$];
  conv_pkg::pixel_t got [$];
  conv_pkg::pixel_t expected [$];
  int               err_result;
  int               err_bus;
  int               err_other;
  int unsigned      cycles;
  int unsigned      cycle_limit;

  conv_top #(
    .IMAGE_WIDTH (IMAGE_WIDTH),
    .IMAGE_HEIGHT(IMAGE_HEIGHT)
  ) uut (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .pix_valid(pix_valid),
    .pix_data (pix_data),
    .out_valid(out_valid),
    .out_data (out_data)
  );

  always #4 clk = ~clk;

  // out_data is settled by the falling edge
  always @(negedge clk) begin
    if (!reset && out_valid) begin
      got.push_back(out_data);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout, the run was still busy after %0d cycles", cycle_limit);
      err_other++;
      report_counts();
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic report_counts();
    $display("errors: results %0d, bus %0d, assertions %0d, other %0d",
             err_result, err_bus, uut.u_sva.fail_count, err_other);
  endtask

  // hex numbers after the op letter up to any # comment
  function automatic void parse_fields(input string line);
    logic [31:0] acc;
    logic        in_tok;
    logic        is_hex;
    logic [7:0]  ch;
    logic [3:0]  nib;
    fields.delete();
    acc    = '0;
    in_tok = 1'b0;
    for (int i = 1; i < line.len(); i++) begin
      ch     = line[i];
      is_hex = 1'b1;
      nib    = '0;
      if (ch == "#") break;
      if (ch >= "0" && ch <= "9") nib = 4'(ch - "0");
      else if (ch >= "a" && ch <= "f") nib = 4'(ch - "a" + 10);
      else if (ch >= "A" && ch <= "F") nib = 4'(ch - "A" + 10);
      else is_hex = 1'b0;
      if (is_hex) begin
        acc    = {acc[27:0], nib};
        in_tok = 1'b1;
      end else if (in_tok) begin
        fields.push_back(acc);
        acc    = '0;
        in_tok = 1'b0;
      end
    end
    if (in_tok) fields.push_back(acc);
  endfunction

  task automatic axil_write(input csr_pkg::addr_t addr, input csr_pkg::data_t data,
                            input csr_pkg::strb_t strb, input csr_pkg::resp_t resp_exp);
    int             gap;
    csr_pkg::resp_t resp;
    @(negedge clk);
    pix_valid        = 1'b0;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    resp = axil_rsp.bresp;
    gap  = $urandom_range(MAX_GAP, 0);
    repeat (gap) @(negedge clk);
    axil_req.bready = 1'b1;
    @(negedge clk);
    axil_req.bready = 1'b0;
    assert (resp == resp_exp) else begin
      $display("** Error: bresp at 0x%02h got 0x%0h expected 0x%0h", addr, resp, resp_exp);
      err_bus++;
    end
  endtask

  task automatic axil_read(input csr_pkg::addr_t addr, input csr_pkg::data_t data_exp,
                           input csr_pkg::resp_t resp_exp);
    int             gap;
    csr_pkg::data_t data;
    csr_pkg::resp_t resp;
    @(negedge clk);
    pix_valid        = 1'b0;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    axil_req.arvalid = 1'b0;
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    gap  = $urandom_range(MAX_GAP, 0);
    repeat (gap) @(negedge clk);
    axil_req.rready = 1'b1;
    @(negedge clk);
    axil_req.rready = 1'b0;
    assert (data == data_exp) else begin
      $display("** Error: rdata at 0x%02h got 0x%08h expected 0x%08h", addr, data, data_exp);
      err_bus++;
    end
    assert (resp == resp_exp) else begin
      $display("** Error: rresp at 0x%02h got 0x%0h expected 0x%0h", addr, resp, resp_exp);
      err_bus++;
    end
  endtask

  // one pixel and sometimes a few idle cycles with junk data
  task automatic send_pixel(input conv_pkg::pixel_t value);
    int gap;
    gap = ($urandom_range(3, 0) == 0) ? $urandom_range(MAX_GAP, 1) : 0;
    @(negedge clk);
    pix_valid = 1'b1;
    pix_data  = value;
    if (gap > 0) begin
      @(negedge clk);
      pix_valid = 1'b0;
      pix_data  = conv_pkg::pixel_t'($urandom);
      repeat (gap - 1) @(negedge clk);
    end
  endtask

  task automatic check_results();
    int n;
    @(negedge clk);
    pix_valid = 1'b0;
    while (got.size() < expected.size()) @(negedge clk);
    // catch anything beyond the expected results
    repeat (4) @(negedge clk);
    assert (got.size() == expected.size()) else begin
      $display("** Error: result count got 0x%0h expected 0x%0h", got.size(), expected.size());
      err_result++;
    end
    n = (got.size() < expected.size()) ? got.size() : expected.size();
    for (int i = 0; i < n; i++) begin
      assert (got[i] == expected[i]) else begin
        $display("** Error: out_data result %0d got 0x%02h expected 0x%02h",
                 i, got[i], expected[i]);
        err_result++;
      end
    end
    got.delete();
    expected.delete();
  endtask

  task automatic run_line(input string line);
    logic ok;
    parse_fields(line);
    case (line[0])
      "w": ok = (fields.size() == 4);
      "r": ok = (fields.size() == 3);
      "p": ok = (fields.size() == IMAGE_WIDTH);
      "e": ok = (fields.size() == RESULTS_ROW);
      "s": ok = (fields.size() == 0);
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      $display("malformed line in the test file: %s", line);
      err_other++;
    end else if (line[0] == "w") begin
      axil_write(fields[0][7:0], fields[1], fields[2][3:0], fields[3][1:0]);
    end else if (line[0] == "r") begin
      axil_read(fields[0][7:0], fields[1], fields[2][1:0]);
    end else if (line[0] == "p") begin
      foreach (fields[i]) send_pixel(fields[i][7:0]);
    end else if (line[0] == "e") begin
      foreach (fields[i]) expected.push_back(fields[i][7:0]);
    end else begin
      check_results();
    end
  endtask

  initial begin
    string line;
    int    fd;
    int    code;
    int    pixels;
    int    accesses;
    int    syncs;
    void'($urandom(SEED));
    clk         = 1'b0;
    reset       = 1'b1;
    axil_req    = '0;
    pix_valid   = 1'b0;
    pix_data    = '0;
    err_result  = 0;
    err_bus     = 0;
    err_other   = 0;
    cycles      = 0;
    pixels      = 0;
    accesses    = 0;
    syncs       = 0;

    // load the op lines and size the run from them
    fd = $fopen("testbench/conv_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/conv_tests.txt");
      err_other++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line[0] != "#") begin
          lines.push_back(line);
          if (line[0] == "p") pixels += IMAGE_WIDTH;
          if (line[0] == "w" || line[0] == "r") accesses++;
          if (line[0] == "s") syncs++;
        end
      end
      $fclose(fd);
    end
    if (lines.size() == 0) begin
      $display("the test file holds no operations");
      err_other++;
    end
    cycle_limit = 100 + pixels * (MAX_GAP + 1) + accesses * (2 * MAX_GAP + 6)
                + (syncs + 1) * 16;

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    foreach (lines[i]) run_line(lines[i]);
    // nothing may arrive after the last expected result
    check_results();

    report_counts();
    if (err_result + err_bus + err_other + uut.u_sva.fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/conv_tb_sva.sv ====
`timescale 1ns/100ps

module conv_tb_sva (
  input logic               clk,
  input logic               reset,
  input csr_pkg::axil_req_t axil_req,
  input csr_pkg::axil_rsp_t axil_rsp,
  input logic               win_valid,
  input logic               out_valid
);

  int unsigned fail_count = 0;

  //////////////////////////////////////////////////
  // register bus responses
  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // a response needs a completed address handshake
  a_write_handshake: assert property (@(posedge clk) disable iff (reset)
    $rose(axil_rsp.bvalid) |-> $past(axil_req.awvalid && axil_req.wvalid
                                      && axil_rsp.awready && axil_rsp.wready))
    else begin
      $error("bvalid rose without awready and wready on the write");
      fail_count++;
    end

  a_read_handshake: assert property (@(posedge clk) disable iff (reset)
    $rose(axil_rsp.rvalid) |-> $past(axil_req.arvalid && axil_rsp.arready))
    else begin
      $error("rvalid rose without arready on the read");
      fail_count++;
    end

  //////////////////////////////////////////////////
  // result stream trails the window by two stages
  a_out_follows_win: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> ##2 out_valid)
    else begin
      $error("out_valid missing two cycles after win_valid");
      fail_count++;
    end

  a_out_has_win: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> $past(win_valid, 2))
    else begin
      $error("out_valid without win_valid two cycles earlier");
      fail_count++;
    end

  // first cycle out of reset
  a_reset_idle: assert property (@(posedge clk)
    $fell(reset) |-> !axil_rsp.bvalid && !axil_rsp.rvalid && !out_valid)
    else begin
      $error("valid outputs high right after reset");
      fail_count++;
    end

endmodule

bind conv_top conv_tb_sva u_sva (
  .clk      (clk),
  .reset    (reset),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .win_valid(win_valid),
  .out_valid(out_valid)
);

// ==== src/conv_top.sv ====
`timescale 1ns/100ps

module conv_top #(
  parameter int IMAGE_WIDTH  = 8,
  parameter int IMAGE_HEIGHT = 6
) (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::axil_req_t axil_req,
  output csr_pkg::axil_rsp_t axil_rsp,
  input  logic               pix_valid,
  input  conv_pkg::pixel_t   pix_data,
  output logic               out_valid,
  output conv_pkg::pixel_t   out_data
);

  conv_pkg::conv_cfg_t cfg;
  conv_pkg::window_t   window;
  logic                win_valid;

  // register slave, also counts results
  conv_csr u_csr (
    .clk         (clk),
    .reset       (reset),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .result_valid(out_valid),
    .cfg         (cfg)
  );

  // 3x3 window from the raster stream
  window_gen #(
    .IMAGE_WIDTH (IMAGE_WIDTH),
    .IMAGE_HEIGHT(IMAGE_HEIGHT)
  ) u_window_gen (
    .clk      (clk),
    .reset    (reset),
    .pix_valid(pix_valid),
    .pix_data (pix_data),
    .enable   (cfg.enable),
    .win_valid(win_valid),
    .window   (window)
  );

  // two cycles from window to result
  conv_mac u_mac (
    .clk      (clk),
    .reset    (reset),
    .win_valid(win_valid),
    .window   (window),
    .kernel   (cfg.kernel),
    .shift    (cfg.shift),
    .out_valid(out_valid),
    .out_data (out_data)
  );

endmodule

// ==== src/conv_csr.sv ====
`timescale 1ns/100ps

module conv_csr (
  input  logic                clk,
  input  logic                reset,
  input  csr_pkg::axil_req_t  axil_req,
  output csr_pkg::axil_rsp_t  axil_rsp,
  input  logic                result_valid,
  output conv_pkg::conv_cfg_t cfg
);

  typedef enum logic {wr_idle, wr_resp} wr_state_t;
  typedef enum logic {rd_idle, rd_data} rd_state_t;

  wr_state_t      wr_state;
  rd_state_t      rd_state;
  csr_pkg::data_t count;
  csr_pkg::resp_t bresp_q;
  csr_pkg::resp_t rresp_q;
  csr_pkg::data_t rdata_q;
  csr_pkg::data_t rd_word;
  csr_pkg::resp_t rd_resp;
  csr_pkg::addr_t wr_off;
  csr_pkg::addr_t rd_off;
  logic           wr_fire;
  logic           rd_fire;
  logic           count_clear;

  // offset inside the weight block, word aligned
  function automatic logic weight_hit(csr_pkg::addr_t off);
    return (off[1:0] == 2'b00) && (off < csr_pkg::addr_t'(4 * conv_pkg::TAPS));
  endfunction

  assign wr_off  = axil_req.awaddr - csr_pkg::WEIGHT_BASE;
  assign rd_off  = axil_req.araddr - csr_pkg::WEIGHT_BASE;
  assign wr_fire = (wr_state == wr_idle) && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = (rd_state == rd_idle) && axil_req.arvalid;

  //////////////////////////////////////////////////
  // write channel and config registers
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state <= wr_idle;
      bresp_q  <= csr_pkg::RESP_OKAY;
      cfg      <= '0;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (wr_fire) begin
            wr_state <= wr_resp;
            bresp_q  <= csr_pkg::RESP_OKAY;
            if (weight_hit(wr_off)) begin
              // low byte only
              if (axil_req.wstrb[0]) begin
                cfg.kernel.w[wr_off[5:2]] <= axil_req.wdata[7:0];
              end
            end else if (axil_req.awaddr == csr_pkg::CTRL_ADDR) begin
              if (axil_req.wstrb[0]) begin
                cfg.enable <= axil_req.wdata[csr_pkg::CTRL_EN_BIT];
                cfg.shift  <= axil_req.wdata[csr_pkg::CTRL_SHIFT_LSB +: 4];
              end
            end else if (axil_req.awaddr != csr_pkg::COUNT_ADDR) begin
              bresp_q <= csr_pkg::RESP_SLVERR;
            end
          end
        end
        wr_resp: begin
          if (axil_req.bready) begin
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // result counter, clear wins over a same-cycle increment
  assign count_clear = wr_fire && (axil_req.awaddr == csr_pkg::COUNT_ADDR);

  always_ff @(posedge clk) begin
    if (reset || count_clear) begin
      count <= '0;
    end else if (result_valid) begin
      count <= count + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // read channel
  always_comb begin
    rd_word = '0;
    rd_resp = csr_pkg::RESP_OKAY;
    if (weight_hit(rd_off)) begin
      rd_word = {24'b0, cfg.kernel.w[rd_off[5:2]]};
    end else if (axil_req.araddr == csr_pkg::CTRL_ADDR) begin
      rd_word = {24'b0, cfg.shift, 3'b0, cfg.enable};
    end else if (axil_req.araddr == csr_pkg::COUNT_ADDR) begin
      rd_word = count;
    end else begin
      rd_resp = csr_pkg::RESP_SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (rd_fire) begin
            rd_state <= rd_data;
          end
        end
        rd_data: begin
          if (axil_req.rready) begin
            rd_state <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // captured at the address handshake
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.bvalid  = (wr_state == wr_resp);
    axil_rsp.arready = (rd_state == rd_idle);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
    axil_rsp.rvalid  = (rd_state == rd_data);
  end

endmodule

// ==== src/conv_mac.sv ====
`timescale 1ns/100ps

module conv_mac (
  input  logic              clk,
  input  logic              reset,
  input  logic              win_valid,
  input  conv_pkg::window_t window,
  input  conv_pkg::kernel_t kernel,
  input  conv_pkg::shift_t  shift,
  output logic              out_valid,
  output conv_pkg::pixel_t  out_data
);

  conv_pkg::prod_t  prod_q [conv_pkg::TAPS];
  conv_pkg::acc_t   row_sum [conv_pkg::KERNEL];
  conv_pkg::acc_t   sum;
  conv_pkg::acc_t   scaled;
  conv_pkg::pixel_t clamped;
  logic             valid_q;

  // stage one, nine signed products
  always_ff @(posedge clk) begin
    for (int k = 0; k < conv_pkg::TAPS; k++) begin
      prod_q[k] <= $signed({1'b0, window.tap[k]}) * $signed(kernel.w[k]);
    end
  end

  // adder tree, one sum per window row then the total
  always_comb begin
    for (int r = 0; r < conv_pkg::KERNEL; r++) begin
      row_sum[r] = conv_pkg::acc_t'(prod_q[3*r])
                 + conv_pkg::acc_t'(prod_q[3*r+1])
                 + conv_pkg::acc_t'(prod_q[3*r+2]);
    end
    sum = row_sum[0] + row_sum[1] + row_sum[2];
  end

  // arithmetic shift, then clamp into pixel range
  always_comb begin
    scaled = sum >>> shift;
    if (scaled < 0) begin
      clamped = 8'h00;
    end else if (scaled > 255) begin
      clamped = 8'hff;
    end else begin
      clamped = scaled[7:0];
    end
  end

  // stage two
  always_ff @(posedge clk) begin
    out_data <= clamped;
  end

  // valid travels with the data
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_q   <= win_valid;
      out_valid <= valid_q;
    end
  end

endmodule

// ==== src/window_gen.sv ====
`timescale 1ns/100ps

module window_gen #(
  parameter int IMAGE_WIDTH  = 8,
  parameter int IMAGE_HEIGHT = 6
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              pix_valid,
  input  conv_pkg::pixel_t  pix_data,
  input  logic              enable,
  output logic              win_valid,
  output conv_pkg::window_t window
);

  localparam int COL_W = $clog2(IMAGE_WIDTH);
  localparam int ROW_W = $clog2(IMAGE_HEIGHT);
  // three column registers plus the line buffer make one image line
  localparam int DEPTH = IMAGE_WIDTH - conv_pkg::KERNEL;

  logic              accept;
  logic              enable_q;
  logic [COL_W-1:0]  col;
  logic [ROW_W-1:0]  row;
  conv_pkg::pixel_t  lb_row1_out;
  conv_pkg::pixel_t  lb_row0_out;
  conv_pkg::window_t win_q;

  assign accept = pix_valid && enable;

  //////////////////////////////////////////////////
  // row delay lines
  // row 2 left tap into row 1 right tap
  line_buffer #(
    .DEPTH(DEPTH)
  ) u_lb_row1 (
    .clk     (clk),
    .reset   (reset),
    .valid_in(accept),
    .data_in (win_q.tap[6]),
    .data_out(lb_row1_out)
  );

  // row 1 left tap into row 0 right tap
  line_buffer #(
    .DEPTH(DEPTH)
  ) u_lb_row0 (
    .clk     (clk),
    .reset   (reset),
    .valid_in(accept),
    .data_in (win_q.tap[3]),
    .data_out(lb_row0_out)
  );

  //////////////////////////////////////////////////
  // column registers, data moves right to left
  always_ff @(posedge clk) begin
    if (accept) begin
      win_q.tap[8] <= pix_data;
      win_q.tap[7] <= win_q.tap[8];
      win_q.tap[6] <= win_q.tap[7];
      win_q.tap[5] <= lb_row1_out;
      win_q.tap[4] <= win_q.tap[5];
      win_q.tap[3] <= win_q.tap[4];
      win_q.tap[2] <= lb_row0_out;
      win_q.tap[1] <= win_q.tap[2];
      win_q.tap[0] <= win_q.tap[1];
    end
  end

  //////////////////////////////////////////////////
  // position of the next pixel in the frame
  always_ff @(posedge clk) begin
    if (reset) begin
      enable_q  <= 1'b0;
      col       <= '0;
      row       <= '0;
      win_valid <= 1'b0;
    end else begin
      enable_q <= enable;
      // only windows fully inside the image
      win_valid <= accept && (row >= conv_pkg::KERNEL - 1) && (col >= conv_pkg::KERNEL - 1);
      if (enable_q && !enable) begin
        // disable restarts the frame
        col <= '0;
        row <= '0;
      end else if (accept) begin
        if (col == COL_W'(IMAGE_WIDTH - 1)) begin
          col <= '0;
          row <= (row == ROW_W'(IMAGE_HEIGHT - 1)) ? '0 : row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  assign window = win_q;

endmodule

// ==== src/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer #(
  parameter int DEPTH = 5
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             valid_in,
  input  conv_pkg::pixel_t data_in,
  output conv_pkg::pixel_t data_out
);

  // chain[0] is the newest entry
  conv_pkg::pixel_t chain [DEPTH];

  // shifts only on accepted pixels, so idle cycles leave the line intact
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        chain[i] <= '0;
      end
    end else if (valid_in) begin
      chain[0] <= data_in;
      for (int i = 1; i < DEPTH; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  // oldest entry
  assign data_out = chain[DEPTH-1];

endmodule

// ==== src/csr_pkg.sv ====
package csr_pkg;

  // byte address and data word of the register bus
  typedef logic [7:0]  addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  //////////////////////////////////////////////////
  // response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  //////////////////////////////////////////////////
  // register map
  // weight k lives at WEIGHT_BASE + 4k
  localparam addr_t WEIGHT_BASE = 8'h00;
  localparam addr_t CTRL_ADDR   = 8'h24;
  // read-only count, any write clears it
  localparam addr_t COUNT_ADDR  = 8'h28;

  // ctrl field positions
  localparam int CTRL_EN_BIT    = 0;
  localparam int CTRL_SHIFT_LSB = 4;

  // host to slave
  typedef struct packed {
    addr_t awaddr;
    logic  awvalid;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  bready;
    addr_t araddr;
    logic  arvalid;
    logic  rready;
  } axil_req_t;

  // slave to host
  typedef struct packed {
    logic  awready;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
  } axil_rsp_t;

endpackage

// ==== src/conv_pkg.sv ====
package conv_pkg;

  // window side, the multiplier tree is built for this
  localparam int KERNEL = 3;
  localparam int TAPS   = KERNEL * KERNEL;

  // grayscale sample
  typedef logic [7:0] pixel_t;

  // signed kernel coefficient
  typedef logic signed [7:0] weight_t;

  // one tap product, 9-bit zero-extended pixel times weight
  typedef logic signed [16:0] prod_t;

  // nine products summed
  typedef logic signed [19:0] acc_t;

  // right shift applied to the sum
  typedef logic [3:0] shift_t;

  // tap k = row*3 + column, row 0 on top, column 0 on the left
  typedef struct packed {
    pixel_t [TAPS-1:0] tap;
  } window_t;

  // same indexing as the window
  typedef struct packed {
    weight_t [TAPS-1:0] w;
  } kernel_t;

  typedef struct packed {
    kernel_t kernel;
    shift_t  shift;
    logic    enable;
  } conv_cfg_t;

endpackage
